// File: vga_core.f
+incdir+logic
logic/vga_pkg.sv
logic/vga_regs.sv
logic/vga_timing.sv
logic/vga_background.sv
logic/vga_pixel_out.sv
logic/vga_core.sv
bench/vga_core_asserts.sv
bench/vga_core_tb.sv

// File: bench/vga_core_tb.sv
`include "vga_settings.svh"

module vga_core_tb
    import vga_pkg::*;
();

    localparam coord_t H_ACT_START  = 10'd2;
    localparam coord_t H_ACT_END    = 10'd34;
    localparam coord_t H_SYNC_START = 10'd38;
    localparam coord_t H_SYNC_END   = 10'd44;
    localparam coord_t V_ACT_START  = 10'd1;
    localparam coord_t V_ACT_END    = 10'd5;
    localparam coord_t V_SYNC_START = 10'd6;
    localparam coord_t V_SYNC_END   = 10'd7;
    localparam int FRAME = (int'(H_SYNC_END) + 1) * (int'(V_SYNC_END) + 1);
    localparam int WATCHDOG_CYCLES = 4 * FRAME + 2000;  // Frame scans plus bus and reset traffic

    logic                   clk;
    logic                   reset;
    logic [31:0]            wb_addr;
    logic [31:0]            wb_data;
    logic                   wb_we;
    logic                   wb_stb;
    logic                   wb_cyc;
    logic                   wb_ack;
    logic [`VGA_CHAN_W-1:0] vga_r, vga_g, vga_b;
    logic                   vga_hs, vga_vs;
    color_t                 pal [4] = '{12'h123, 12'h4a5, 12'h9c0, 12'hf0e};  // All nonzero
    pattern_t               pat0, pat1;
    pix_width_t             size0, size1;
    integer                 seed = 32'hdb75;

    vga_core i_vga_core (
        .clk(clk), .reset(reset),
        .wb_addr_i(wb_addr), .wb_data_i(wb_data), .wb_we_i(wb_we),
        .wb_stb_i(wb_stb), .wb_cyc_i(wb_cyc), .wb_ack_o(wb_ack),
        .vga_r_o(vga_r), .vga_g_o(vga_g), .vga_b_o(vga_b),
        .vga_hs_o(vga_hs), .vga_vs_o(vga_vs)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles with tests still running", WATCHDOG_CYCLES);
        abort_run();
    end

    task automatic abort_run();
        $display("Verification failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_color(input string name, input color_t got, input color_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    function automatic logic [31:0] reg_addr(input logic [7:0] offset);
        return {`VGA_BASE, 16'h0000, offset};
    endfunction

    function automatic logic [31:0] ctrl_word(input logic en, input logic hp, input logic vp);
        return {9'b0, en, hp, vp, H_ACT_END, V_ACT_END};
    endfunction

    // Each pattern bit lasts size+1 clocks from the start of the visible line
    function automatic bg_index_t expected_index(input int h);
        int k;
        k = h - int'(H_ACT_START);
        return {pat1[(k / (int'(size1) + 1)) % 32], pat0[(k / (int'(size0) + 1)) % 32]};
    endfunction

    task automatic bus_access(input logic [31:0] addr, input logic [31:0] data, input logic we);
        int waited;
        @(posedge clk);
        wb_addr <= addr;
        wb_data <= data;
        wb_we   <= we;
        wb_stb  <= 1'b1;
        wb_cyc  <= 1'b1;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > 20) begin
                $display("Bus access to %h was not acknowledged within 20 cycles", addr);
                abort_run();
            end
        end while (wb_ack !== 1'b1);
        @(posedge clk);
        wb_stb <= 1'b0;
        wb_cyc <= 1'b0;
        wb_we  <= 1'b0;
        repeat (2) @(negedge clk);
        check_bit("wb_ack_o", wb_ack, 1'b0);    // Ack drops once strobe is gone
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
        bus_access(addr, data, 1'b1);
    endtask

    task automatic bus_read(input logic [31:0] addr);
        bus_access(addr, 32'h0, 1'b0);
    endtask

    // Waits for the start of the vertical pulse, then checks every output for one frame
    task automatic scan_frame(input logic hp, input logic vp);
        int     h;
        int     v;
        int     waited;
        logic   vs_prev;
        color_t exp_col;
        bus_write(reg_addr(`VGA_REG_BG0), pat0);
        bus_write(reg_addr(`VGA_REG_BG1), pat1);
        bus_write(reg_addr(`VGA_REG_BGSIZE), {20'b0, size0, size1});
        bus_write(reg_addr(`VGA_REG_CTRL), ctrl_word(1'b1, hp, vp));
        waited = 0;
        do begin
            vs_prev = vga_vs;
            @(negedge clk);
            waited++;
            if (waited > 2 * FRAME) begin
                $display("No vertical sync pulse seen within %0d cycles", 2 * FRAME);
                abort_run();
            end
        end while (!(vs_prev !== vp && vga_vs === vp));
        h = 0;                                  // Output now shows pixel 0 of the pulse line
        v = V_SYNC_START;
        repeat (FRAME) begin
            exp_col = '0;
            if (h >= H_ACT_START && h < H_ACT_END && v >= V_ACT_START && v < V_ACT_END) begin
                exp_col = pal[expected_index(h)];
            end
            check_color($sformatf("vga_rgb at h %0d v %0d", h, v),
                        {vga_r, vga_g, vga_b}, exp_col);
            check_bit("vga_hs_o", vga_hs, (h >= H_SYNC_START && h < H_SYNC_END) ? hp : !hp);
            check_bit("vga_vs_o", vga_vs, (v >= V_SYNC_START && v < V_SYNC_END) ? vp : !vp);
            if (h == H_SYNC_END) begin
                h = 0;
                v = (v == V_SYNC_END) ? 0 : v + 1;
            end else begin
                h++;
            end
            @(negedge clk);
        end
    endtask

    task automatic test_bus_ack();
        bus_write(reg_addr(`VGA_REG_HTIME), {2'b0, H_SYNC_START, H_SYNC_END, H_ACT_START});
        bus_write(reg_addr(`VGA_REG_VTIME), {2'b0, V_SYNC_START, V_SYNC_END, V_ACT_START});
        bus_write(reg_addr(`VGA_REG_PAL01), {8'h0, pal[1], pal[0]});
        bus_write(reg_addr(`VGA_REG_PAL23), {8'h0, pal[3], pal[2]});
        bus_write(reg_addr(8'h18), 32'hffff_ffff);  // Unused offset
        bus_read(reg_addr(`VGA_REG_HTIME));
        @(posedge clk);
        wb_addr <= {8'h31, 24'h000008};             // Neighbouring address block
        wb_data <= 32'hffff_ffff;
        wb_we   <= 1'b1;
        wb_stb  <= 1'b1;
        wb_cyc  <= 1'b1;
        repeat (20) begin
            @(negedge clk);
            check_bit("wb_ack_o", wb_ack, 1'b0);
        end
        @(posedge clk);
        wb_stb <= 1'b0;
        wb_cyc <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic test_disabled();
        bus_write(reg_addr(`VGA_REG_CTRL), ctrl_word(1'b0, 1'b1, 1'b0));
        repeat (100) begin
            @(negedge clk);
            check_color("vga_rgb", {vga_r, vga_g, vga_b}, '0);
            check_bit("vga_hs_o", vga_hs, 1'b0);    // Idle levels are the inverted polarities
            check_bit("vga_vs_o", vga_vs, 1'b1);
        end
    endtask

    task automatic test_fixed_patterns();
        pat0  = '0;
        pat1  = '0;
        size0 = '0;
        size1 = '0;
        scan_frame(1'b1, 1'b1);
        pat0 = '1;
        pat1 = '1;
        scan_frame(1'b1, 1'b1);
        pat0  = 32'h5555_5555;                      // Runs of 3, entry 1 first
        pat1  = '0;
        size0 = 6'd2;
        scan_frame(1'b1, 1'b1);
    endtask

    task automatic test_random_patterns();
        pat0  = $random(seed);
        pat1  = $random(seed);
        size0 = pix_width_t'($random(seed) & 3);
        size1 = pix_width_t'($random(seed) & 3);
        scan_frame(1'b0, 1'b1);                     // Negative horizontal sync
    endtask

    initial begin
        reset   = 1'b1;
        wb_addr = '0;
        wb_data = '0;
        wb_we   = 1'b0;
        wb_stb  = 1'b0;
        wb_cyc  = 1'b0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        test_bus_ack();
        test_disabled();
        test_fixed_patterns();
        test_random_patterns();
        $display("Verification passed");
        $finish;
    end

endmodule

// File: bench/vga_core_asserts.sv
`include "vga_settings.svh"

module vga_core_asserts
    import vga_pkg::*;
(
    input logic        clk,
    input logic        reset,
    input logic        pixel_valid_i,
    input color_t      color_i,
    input logic        hs_i,
    input logic        vs_i,
    input logic [31:0] wb_addr_i,
    input logic        wb_stb_i,
    input logic        wb_cyc_i,
    input logic        wb_ack_i
);

    logic addressed;

    assign addressed = wb_stb_i && wb_cyc_i && (wb_addr_i[31:24] == `VGA_BASE);

    blank_after_invalid: assert property (@(posedge clk) disable iff (reset)
        !pixel_valid_i |=> color_i == '0)
        else $error("Colour output not black one clock after an invalid pixel");

    ack_after_access: assert property (@(posedge clk) disable iff (reset)
        wb_ack_i |-> $past(addressed))
        else $error("Bus ack raised without an addressed cycle before it");

    sync_known: assert property (@(posedge clk) disable iff (reset)
        !$isunknown({hs_i, vs_i}))
        else $error("Sync output unknown after reset");

endmodule

// Bus port and video outputs of the core
bind vga_core vga_core_asserts i_core_asserts (
    .clk           (clk),
    .reset         (reset),
    .pixel_valid_i (pixel_valid),
    .color_i       ({vga_r_o, vga_g_o, vga_b_o}),
    .hs_i          (vga_hs_o),
    .vs_i          (vga_vs_o),
    .wb_addr_i     (wb_addr_i),
    .wb_stb_i      (wb_stb_i),
    .wb_cyc_i      (wb_cyc_i),
    .wb_ack_i      (wb_ack_o)
);

// File: logic/vga_core.sv
`include "vga_settings.svh"

module vga_core
    import vga_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,

    input  logic [31:0]            wb_addr_i,
    input  logic [31:0]            wb_data_i,
    input  logic                   wb_we_i,
    input  logic                   wb_stb_i,
    input  logic                   wb_cyc_i,
    output logic                   wb_ack_o,

    output logic [`VGA_CHAN_W-1:0] vga_r_o,
    output logic [`VGA_CHAN_W-1:0] vga_g_o,
    output logic [`VGA_CHAN_W-1:0] vga_b_o,
    output logic                   vga_hs_o,
    output logic                   vga_vs_o
);

    logic         enabled;
    logic         h_pol;
    logic         v_pol;
    coord_t       h_sync_start;
    coord_t       h_sync_end;
    coord_t       h_active_start;
    coord_t       h_active_end;
    coord_t       v_sync_start;
    coord_t       v_sync_end;
    coord_t       v_active_start;
    coord_t       v_active_end;
    pattern_t     bg_pattern0;
    pattern_t     bg_pattern1;
    pix_width_t   bg_size0;
    pix_width_t   bg_size1;
    color_t [3:0] palette;

    logic         h_sync;
    logic         v_sync;
    logic         h_active;
    logic         v_active;
    bg_index_t    bg_index;
    logic         pixel_valid;

    vga_regs i_vga_regs (
        .clk              (clk),
        .reset            (reset),
        .wb_addr_i        (wb_addr_i),
        .wb_data_i        (wb_data_i),
        .wb_we_i          (wb_we_i),
        .wb_stb_i         (wb_stb_i),
        .wb_cyc_i         (wb_cyc_i),
        .wb_ack_o         (wb_ack_o),
        .enabled_o        (enabled),
        .h_pol_o          (h_pol),
        .v_pol_o          (v_pol),
        .h_sync_start_o   (h_sync_start),
        .h_sync_end_o     (h_sync_end),
        .h_active_start_o (h_active_start),
        .h_active_end_o   (h_active_end),
        .v_sync_start_o   (v_sync_start),
        .v_sync_end_o     (v_sync_end),
        .v_active_start_o (v_active_start),
        .v_active_end_o   (v_active_end),
        .bg_pattern0_o    (bg_pattern0),
        .bg_pattern1_o    (bg_pattern1),
        .bg_size0_o       (bg_size0),
        .bg_size1_o       (bg_size1),
        .palette_o        (palette)
    );

    vga_timing i_vga_timing (
        .clk              (clk),
        .reset            (reset),
        .enabled_i        (enabled),
        .h_pol_i          (h_pol),
        .v_pol_i          (v_pol),
        .h_sync_start_i   (h_sync_start),
        .h_sync_end_i     (h_sync_end),
        .h_active_start_i (h_active_start),
        .h_active_end_i   (h_active_end),
        .v_sync_start_i   (v_sync_start),
        .v_sync_end_i     (v_sync_end),
        .v_active_start_i (v_active_start),
        .v_active_end_i   (v_active_end),
        .h_sync_o         (h_sync),
        .v_sync_o         (v_sync),
        .h_active_o       (h_active),
        .v_active_o       (v_active)
    );

    vga_background i_vga_background (
        .clk           (clk),
        .reset         (reset),
        .h_active_i    (h_active),
        .v_active_i    (v_active),
        .bg_pattern0_i (bg_pattern0),
        .bg_pattern1_i (bg_pattern1),
        .bg_size0_i    (bg_size0),
        .bg_size1_i    (bg_size1),
        .bg_index_o    (bg_index),
        .pixel_valid_o (pixel_valid)
    );

    vga_pixel_out i_vga_pixel_out (
        .clk           (clk),
        .reset         (reset),
        .palette_i     (palette),
        .bg_index_i    (bg_index),
        .pixel_valid_i (pixel_valid),
        .h_sync_i      (h_sync),
        .v_sync_i      (v_sync),
        .vga_r_o       (vga_r_o),
        .vga_g_o       (vga_g_o),
        .vga_b_o       (vga_b_o),
        .vga_hs_o      (vga_hs_o),
        .vga_vs_o      (vga_vs_o)
    );

endmodule

// File: logic/vga_pixel_out.sv
`include "vga_settings.svh"

module vga_pixel_out
    import vga_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,

    input  color_t [3:0]           palette_i,
    input  bg_index_t              bg_index_i,
    input  logic                   pixel_valid_i,
    input  logic                   h_sync_i,
    input  logic                   v_sync_i,

    output logic [`VGA_CHAN_W-1:0] vga_r_o,
    output logic [`VGA_CHAN_W-1:0] vga_g_o,
    output logic [`VGA_CHAN_W-1:0] vga_b_o,
    output logic                   vga_hs_o,
    output logic                   vga_vs_o
);

    color_t color_q;

    // Colour and sync share one register stage so they stay aligned
    always_ff @(posedge clk) begin
        if (reset) begin
            color_q  <= '0;
            vga_hs_o <= 1'b0;
            vga_vs_o <= 1'b0;
        end else begin
            vga_hs_o <= h_sync_i;
            vga_vs_o <= v_sync_i;
            if (pixel_valid_i) begin
                color_q <= palette_i[bg_index_i];
            end else begin
                color_q <= '0;             // Blank outside the visible area
            end
        end
    end

    assign vga_r_o = color_q.r;
    assign vga_g_o = color_q.g;
    assign vga_b_o = color_q.b;

endmodule

// File: logic/vga_background.sv
`include "vga_settings.svh"

module vga_background
    import vga_pkg::*;
(
    input  logic       clk,
    input  logic       reset,

    input  logic       h_active_i,
    input  logic       v_active_i,

    input  pattern_t   bg_pattern0_i,
    input  pattern_t   bg_pattern1_i,
    input  pix_width_t bg_size0_i,
    input  pix_width_t bg_size1_i,

    output bg_index_t  bg_index_o,
    output logic       pixel_valid_o
);

    localparam int COL_W = $clog2(`VGA_PATTERN_W);

    pattern_t   pattern [2];
    pix_width_t size [2];
    logic [1:0] layer_bit;
    logic       display_en;

    assign display_en = h_active_i && v_active_i;

    assign pattern[0] = bg_pattern0_i;
    assign pattern[1] = bg_pattern1_i;
    assign size[0]    = bg_size0_i;
    assign size[1]    = bg_size1_i;

    // Both layers step on their own, only the widths differ
    for (genvar n = 0; n < 2; n++) begin : g_layer
        logic [COL_W-1:0] col;         // Current pattern bit
        pix_width_t       width_cnt;   // Clocks spent on this bit

        always_ff @(posedge clk) begin
            if (reset || !display_en) begin
                col       <= '0;       // Restart at bit 0 on every visible line
                width_cnt <= '0;
            end else if (width_cnt >= size[n]) begin
                width_cnt <= '0;
                col       <= col + 1'b1;   // Wraps modulo pattern length
            end else begin
                width_cnt <= width_cnt + 1'b1;
            end
        end

        assign layer_bit[n] = pattern[n][col];
    end

    // Layer 1 is the high index bit
    assign bg_index_o    = {layer_bit[1], layer_bit[0]};
    assign pixel_valid_o = display_en;

endmodule

// File: logic/vga_timing.sv
module vga_timing
    import vga_pkg::*;
(
    input  logic   clk,
    input  logic   reset,

    input  logic   enabled_i,
    input  logic   h_pol_i,
    input  logic   v_pol_i,

    input  coord_t h_sync_start_i,
    input  coord_t h_sync_end_i,
    input  coord_t h_active_start_i,
    input  coord_t h_active_end_i,
    input  coord_t v_sync_start_i,
    input  coord_t v_sync_end_i,
    input  coord_t v_active_start_i,
    input  coord_t v_active_end_i,

    output logic   h_sync_o,
    output logic   v_sync_o,
    output logic   h_active_o,
    output logic   v_active_o
);

    coord_t h_count;
    coord_t v_count;
    logic   h_wrap;
    logic   v_wrap;
    logic   h_in_pulse;
    logic   v_in_pulse;

    // Compare with >= so a shortened line reprogrammed mid-frame still wraps
    assign h_wrap = (h_count >= h_sync_end_i);
    assign v_wrap = (v_count >= v_sync_end_i);

    always_ff @(posedge clk) begin
        if (reset || !enabled_i) begin
            h_count <= '0;             // Counters parked while disabled
            v_count <= '0;
        end else if (h_wrap) begin
            h_count <= '0;
            if (v_wrap) begin
                v_count <= '0;         // End of frame
            end else begin
                v_count <= v_count + 1'b1;
            end
        end else begin
            h_count <= h_count + 1'b1;
        end
    end

    // Active windows, half-open on the end value
    assign h_active_o = enabled_i
                     && (h_count >= h_active_start_i)
                     && (h_count < h_active_end_i);
    assign v_active_o = enabled_i
                     && (v_count >= v_active_start_i)
                     && (v_count < v_active_end_i);

    // Sync pulse windows, before polarity
    assign h_in_pulse = enabled_i
                     && (h_count >= h_sync_start_i)
                     && (h_count < h_sync_end_i);
    assign v_in_pulse = enabled_i
                     && (v_count >= v_sync_start_i)
                     && (v_count < v_sync_end_i);

    // Pulse level is the polarity bit, idle level its inverse
    assign h_sync_o = h_in_pulse ? h_pol_i : !h_pol_i;
    assign v_sync_o = v_in_pulse ? v_pol_i : !v_pol_i;

endmodule

// File: logic/vga_regs.sv
`include "vga_settings.svh"

module vga_regs
    import vga_pkg::*;
(
    input  logic        clk,
    input  logic        reset,

    input  logic [31:0] wb_addr_i,
    input  logic [31:0] wb_data_i,
    input  logic        wb_we_i,
    input  logic        wb_stb_i,
    input  logic        wb_cyc_i,
    output logic        wb_ack_o,

    output logic        enabled_o,
    output logic        h_pol_o,
    output logic        v_pol_o,

    output coord_t      h_sync_start_o,
    output coord_t      h_sync_end_o,
    output coord_t      h_active_start_o,
    output coord_t      h_active_end_o,
    output coord_t      v_sync_start_o,
    output coord_t      v_sync_end_o,
    output coord_t      v_active_start_o,
    output coord_t      v_active_end_o,

    output pattern_t    bg_pattern0_o,
    output pattern_t    bg_pattern1_o,
    output pix_width_t  bg_size0_o,
    output pix_width_t  bg_size1_o,
    output color_t [3:0] palette_o
);

    logic       addressed;
    logic [7:0] offset;

    assign addressed = wb_stb_i && wb_cyc_i && (wb_addr_i[31:24] == `VGA_BASE);
    assign offset    = wb_addr_i[7:0];

    // Ack follows the addressed access one clock late, for reads and writes alike
    always_ff @(posedge clk) begin
        if (reset) begin
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= addressed;
        end
    end

    // Writes land on every addressed cycle; the data is stable while strobe is held
    always_ff @(posedge clk) begin
        if (reset) begin
            enabled_o        <= 1'b0;
            h_pol_o          <= 1'b0;
            v_pol_o          <= 1'b0;
            h_sync_start_o   <= '0;
            h_sync_end_o     <= '0;
            h_active_start_o <= '0;
            h_active_end_o   <= '0;
            v_sync_start_o   <= '0;
            v_sync_end_o     <= '0;
            v_active_start_o <= '0;
            v_active_end_o   <= '0;
            bg_pattern0_o    <= '0;
            bg_pattern1_o    <= '0;
            bg_size0_o       <= '0;
            bg_size1_o       <= '0;
            palette_o        <= '0;
        end else if (addressed && wb_we_i) begin
            case (offset)
                `VGA_REG_HTIME: begin
                    h_sync_start_o   <= wb_data_i[29:20];
                    h_sync_end_o     <= wb_data_i[19:10];
                    h_active_start_o <= wb_data_i[9:0];
                end
                `VGA_REG_VTIME: begin
                    v_sync_start_o   <= wb_data_i[29:20];
                    v_sync_end_o     <= wb_data_i[19:10];
                    v_active_start_o <= wb_data_i[9:0];
                end
                `VGA_REG_CTRL: begin
                    enabled_o      <= wb_data_i[22];
                    h_pol_o        <= wb_data_i[21];
                    v_pol_o        <= wb_data_i[20];
                    h_active_end_o <= wb_data_i[19:10];
                    v_active_end_o <= wb_data_i[9:0];
                end
                `VGA_REG_BG0:    bg_pattern0_o <= wb_data_i;
                `VGA_REG_BG1:    bg_pattern1_o <= wb_data_i;
                `VGA_REG_BGSIZE: begin
                    bg_size0_o <= wb_data_i[11:6];
                    bg_size1_o <= wb_data_i[5:0];
                end
                `VGA_REG_PAL01: begin
                    palette_o[0] <= wb_data_i[11:0];
                    palette_o[1] <= wb_data_i[23:12];
                end
                `VGA_REG_PAL23: begin
                    palette_o[2] <= wb_data_i[11:0];
                    palette_o[3] <= wb_data_i[23:12];
                end
                default: begin
                    // Unused offset, acked above and dropped here
                end
            endcase
        end
    end

endmodule

// File: logic/vga_pkg.sv
`include "vga_settings.svh"

package vga_pkg;

    // Horizontal or vertical position
    typedef logic [`VGA_COORD_W-1:0] coord_t;

    // 12-bit colour, red in the top nibble
    typedef struct packed {
        logic [`VGA_CHAN_W-1:0] r;
        logic [`VGA_CHAN_W-1:0] g;
        logic [`VGA_CHAN_W-1:0] b;
    } color_t;

    // One background bit pattern
    typedef logic [`VGA_PATTERN_W-1:0] pattern_t;

    // Clocks per pattern bit, minus one
    typedef logic [`VGA_PIXW_W-1:0] pix_width_t;

    // Palette index, {layer1, layer0}
    typedef logic [1:0] bg_index_t;

endpackage

// File: logic/vga_settings.svh
`ifndef VGA_SETTINGS_SVH
`define VGA_SETTINGS_SVH

// Datapath widths
`define VGA_COORD_W    10  // Position counters and timing fields
`define VGA_CHAN_W     4   // One colour channel
`define VGA_PATTERN_W  32  // Background pattern length in bits
`define VGA_PIXW_W     6   // Pixel-width field

// Address block of the core, compared against address bits 31 to 24
`define VGA_BASE       8'h30

// Register offsets inside the block
`define VGA_REG_HTIME  8'h00  // h_sync_start, h_sync_end, h_active_start
`define VGA_REG_VTIME  8'h04  // Vertical counterparts
`define VGA_REG_CTRL   8'h08  // Enable, polarities, active ends
`define VGA_REG_BG0    8'h0C  // Background layer 0 pattern
`define VGA_REG_BG1    8'h10  // Background layer 1 pattern
`define VGA_REG_BGSIZE 8'h14  // Pixel widths of both layers
`define VGA_REG_PAL01  8'h1C  // Palette entries 0 and 1
`define VGA_REG_PAL23  8'h20  // Palette entries 2 and 3

`endif
